// ==== files.f ====
+incdir+.
scrypt_pkg.sv
salsa_core.sv
scratchpad_ram.sv
block_datapath.sv
romix_ctrl.sv
salsa_engine.sv
tb_salsa_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing
TOP := tb_salsa_engine
FILELIST := files.f
LOG := sim.log
PASS_MSG := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_scrypt_model.svh ====
/* Reference model of scrypt ROMix for the testbench
 * Salsa20/8, BlockMix with r = 1, byte reordering and ROMix over 2^addr_bits blocks
 */

`ifndef TB_SCRYPT_MODEL_SVH
`define TB_SCRYPT_MODEL_SVH

`default_nettype none

function automatic logic [31:0] rotate_left(input logic [31:0] v, input int n);
	return (v << n) | (v >> (32 - n));
endfunction

// One quarter round on words a, b, c and d of a 16-word state
function automatic logic [511:0] quarter_round(input logic [511:0] s, input int a, input int b,
	input int c, input int d);
	logic [31:0] w [16];
	logic [511:0] r;
	for (int i = 0; i < 16; i++)
		w[i] = s[32*i +: 32];
	w[b] = w[b] ^ rotate_left(w[a] + w[d], 7);
	w[c] = w[c] ^ rotate_left(w[b] + w[a], 9);
	w[d] = w[d] ^ rotate_left(w[c] + w[b], 13);
	w[a] = w[a] ^ rotate_left(w[d] + w[c], 18);
	for (int i = 0; i < 16; i++)
		r[32*i +: 32] = w[i];
	return r;
endfunction

// Eight rounds as four column and row pairs, with the input added at the end
function automatic logic [511:0] salsa20_8(input logic [511:0] in_blk);
	logic [511:0] s;
	logic [511:0] sum;
	s = in_blk;
	for (int r = 0; r < 4; r++)
	begin
		s = quarter_round(s, 0, 4, 8, 12);	// Columns
		s = quarter_round(s, 5, 9, 13, 1);
		s = quarter_round(s, 10, 14, 2, 6);
		s = quarter_round(s, 15, 3, 7, 11);
		s = quarter_round(s, 0, 1, 2, 3);	// Rows
		s = quarter_round(s, 5, 6, 7, 4);
		s = quarter_round(s, 10, 11, 8, 9);
		s = quarter_round(s, 15, 12, 13, 14);
	end
	for (int i = 0; i < 16; i++)
		sum[32*i +: 32] = s[32*i +: 32] + in_blk[32*i +: 32];
	return sum;
endfunction

// BlockMix with r = 1, B0 in the low half and B1 in the high half
function automatic logic [1023:0] block_mix(input logic [1023:0] b);
	logic [511:0] y0;
	logic [511:0] y1;
	y0 = salsa20_8(b[511:0] ^ b[1023:512]);
	y1 = salsa20_8(y0 ^ b[1023:512]);
	return {y1, y0};
endfunction

// Reverses the bytes inside every 32-bit word
function automatic logic [1023:0] swap_word_bytes(input logic [1023:0] x);
	logic [1023:0] w;
	for (int i = 0; i < 32; i++)
		w[32*i +: 32] = {x[32*i +: 8], x[32*i+8 +: 8], x[32*i+16 +: 8], x[32*i+24 +: 8]};
	return w;
endfunction

// ROMix on a block in host byte order, result also in host byte order
function automatic logic [1023:0] romix_reference(input logic [1023:0] blk, input int addr_bits);
	logic [1023:0] v [];
	logic [1023:0] x;
	int n;
	int j;
	n = 1 << addr_bits;
	v = new[n];
	x = swap_word_bytes(blk);
	for (int i = 0; i < n; i++)
	begin
		v[i] = x;	// Fill V[i] before mixing
		x = block_mix(x);
	end
	for (int i = 0; i < n; i++)
	begin
		j = int'(x[512 +: 32] & 32'(n - 1));	// Integerify mod N
		x = block_mix(x ^ v[j]);
	end
	return swap_word_bytes(x);
endfunction

`default_nettype wire

`endif

// ==== tb_salsa_engine.sv ====
/* Testbench for the scrypt ROMix engine with N = 8
 * Serial block exchange, start strobes and checks against the reference model
 */

`timescale 1ns/1ps
`include "tb_scrypt_model.svh"
`default_nettype none

module tb_salsa_engine;

	localparam int ADDR_BITS = 3;	// Small scratchpad keeps each hash short
	localparam int RESULT_TIMEOUT = 1000;	// Cycles allowed from start to result

	logic hash_clk;
	logic reset;
	logic din;
	logic shift;
	logic start;
	logic dout;
	logic busy;
	logic result;
	int seed;
	logic [1023:0] blk_a;
	logic [1023:0] blk_b;
	logic [1023:0] blk_c;
	logic [1023:0] unloaded;	// Last block shifted out of the DUT

	salsa_engine #(.ADDR_BITS(ADDR_BITS)) salsa_engine_inst (
		.hash_clk(hash_clk),
		.reset(reset),
		.din(din),
		.shift(shift),
		.start(start),
		.dout(dout),
		.busy(busy),
		.result(result)
	);

	initial hash_clk = 1'b0;
	always #20 hash_clk = ~hash_clk;	// 40 ns period

	// Everything happens 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge hash_clk);
		#2;
	endtask

	task automatic stop_on_error();
		$display("Something failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string test, input logic [1023:0] expected,
		input logic [1023:0] actual);
		$display("FAIL %s expected %h actual %h", test, expected, actual);
		stop_on_error();
	endtask

	task automatic report_error(input string what);
		$display("FAIL %s", what);
		stop_on_error();
	endtask

	function automatic logic [1023:0] random_block();
		logic [1023:0] r;
		for (int i = 0; i < 32; i++)
			r[32*i +: 32] = $random(seed);
		return r;
	endfunction

	// Shifts one block in while the previous one comes out, MSB first on both lines
	task automatic exchange_block(input logic [1023:0] next_in, output logic [1023:0] shifted_out);
		for (int i = 1023; i >= 0; i--)
		begin
			shifted_out[i] = dout;	// dout is the register MSB before this shift
			din = next_in[i];
			shift = 1'b1;
			next_cycle();
		end
		shift = 1'b0;
		din = 1'b0;
	endtask

	task automatic start_hash(input string test);
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		assert (busy) else report_error({test, ": busy did not rise after start"});
	endtask

	task automatic wait_result(input string test);
		int cycles;
		cycles = 0;
		while (!result)
		begin
			if (cycles == RESULT_TIMEOUT)
				report_error({test, ": timeout while waiting for result"});
			next_cycle();
			cycles++;
		end
		assert (!busy) else report_error({test, ": busy still high in the result cycle"});
		next_cycle();
		assert (!result) else report_error({test, ": result lasted more than one cycle"});
	endtask

	// Neither flag may move while nothing has been started
	task automatic expect_quiet(input string test, input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			assert (!busy && !result)
			else
				report_error({test, ": busy or result high without an accepted start"});
			next_cycle();
		end
	endtask

	task automatic check_block(input string test, input logic [1023:0] expected,
		input logic [1023:0] actual);
		assert (expected === actual) else report_mismatch(test, expected, actual);
	endtask

	initial
	begin
		seed = 41;
		reset = 1'b1;
		din = 1'b0;
		shift = 1'b0;
		start = 1'b0;
		repeat (3) @(posedge hash_clk);
		#2;
		reset = 1'b0;

		expect_quiet("reset_state", 10);

		// All-zero block, the result comes out while the first random block goes in
		exchange_block('0, unloaded);
		start_hash("zero_block");
		wait_result("zero_block");
		blk_a = random_block();
		exchange_block(blk_a, unloaded);
		check_block("zero_block", romix_reference('0, ADDR_BITS), unloaded);

		start_hash("random_block");
		wait_result("random_block");
		blk_b = random_block();
		exchange_block(blk_b, unloaded);
		check_block("random_block", romix_reference(blk_a, ADDR_BITS), unloaded);

		// A second start halfway through the run must be dropped
		start_hash("start_while_busy");
		repeat (50) next_cycle();
		assert (busy) else report_error("start_while_busy: busy fell before the second start");
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_result("start_while_busy");
		expect_quiet("start_while_busy", 300);	// Longer than one whole hash
		blk_c = random_block();
		exchange_block(blk_c, unloaded);
		check_block("start_while_busy", romix_reference(blk_b, ADDR_BITS), unloaded);

		// blk_c went in during the last unload
		start_hash("back_to_back");
		wait_result("back_to_back");
		exchange_block('0, unloaded);
		check_block("back_to_back", romix_reference(blk_c, ADDR_BITS), unloaded);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== salsa_engine.sv ====
/* Top level of the scrypt ROMix engine
 * Connects the controller, datapath, salsa core and scratchpad
 */

`timescale 1ns/1ps
`default_nettype none

module salsa_engine #(
	parameter int ADDR_BITS = 10	// N = 1024 for standard scrypt
) (
	input  logic hash_clk,
	input  logic reset,
	input  logic din,
	input  logic shift,
	input  logic start,
	output logic dout,
	output logic busy,
	output logic result
);

	scrypt_pkg::x_op_t x_op;
	logic salsa_load;
	logic salsa_done;
	logic [scrypt_pkg::HALF_BITS-1:0] salsa_in;
	logic [scrypt_pkg::HALF_BITS-1:0] salsa_out;
	logic [ADDR_BITS-1:0] ram_addr;
	logic ram_we;
	scrypt_pkg::block_t ram_wdata;
	scrypt_pkg::block_t ram_rdata;
	logic [scrypt_pkg::WORD_BITS-1:0] jump_index_word;

	romix_ctrl #(.ADDR_BITS(ADDR_BITS)) romix_ctrl_inst (
		.hash_clk(hash_clk),
		.reset(reset),
		.start(start),
		.salsa_done(salsa_done),
		.jump_index_word(jump_index_word),
		.x_op(x_op),
		.salsa_load(salsa_load),
		.ram_addr(ram_addr),
		.ram_we(ram_we),
		.busy(busy),
		.result(result)
	);

	block_datapath block_datapath_inst (
		.hash_clk(hash_clk),
		.reset(reset),
		.din(din),
		.shift(shift),
		.x_op(x_op),
		.salsa_out(salsa_out),
		.ram_rdata(ram_rdata),
		.dout(dout),
		.salsa_in(salsa_in),
		.ram_wdata(ram_wdata),
		.jump_index_word(jump_index_word)
	);

	salsa_core salsa_core_inst (
		.hash_clk(hash_clk),
		.reset(reset),
		.load(salsa_load),
		.din(salsa_in),
		.dout(salsa_out),
		.done(salsa_done)
	);

	// Scratchpad holds V[0] to V[N-1]
	scratchpad_ram #(.ADDR_BITS(ADDR_BITS)) scratchpad_ram_inst (
		.hash_clk(hash_clk),
		.addr(ram_addr),
		.we(ram_we),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

`default_nettype wire

// ==== romix_ctrl.sv ====
/* ROMix controller
 * Write and mix phase FSM that sequences the salsa core, the scratchpad and the datapath
 * Owns the busy and result flags
 */

`timescale 1ns/1ps
`default_nettype none

module romix_ctrl #(
	parameter int ADDR_BITS = 10
) (
	input  logic hash_clk,
	input  logic reset,
	input  logic start,
	input  logic salsa_done,
	input  logic [scrypt_pkg::WORD_BITS-1:0] jump_index_word,
	output scrypt_pkg::x_op_t x_op,
	output logic salsa_load,
	output logic [ADDR_BITS-1:0] ram_addr,
	output logic ram_we,
	output logic busy,
	output logic result
);

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_write = 3'd1;	// Store V[i]
	localparam logic [2:0] st_mix_read = 3'd2;	// Present V[j] address
	localparam logic [2:0] st_mix_xor = 3'd3;	// Read data arrives
	localparam logic [2:0] st_half_one = 3'd4;
	localparam logic [2:0] st_half_two = 3'd5;
	localparam logic [2:0] st_finish = 3'd6;	// Unload cycle

	logic [2:0] state;
	logic [ADDR_BITS-1:0] iter_cnt;	// Iteration within the current phase
	logic mix_phase;	// Low while the scratchpad is being filled
	logic accept;
	logic last_iter;

	// A start in the result cycle is dropped so the flags stay clean
	assign accept = (state == st_idle) && start && !result;
	assign last_iter = &iter_cnt;

	// Datapath operation follows the state, the takes wait for the salsa pulse
	always_comb
	begin
		x_op = scrypt_pkg::x_hold;
		case (state)
			st_idle:
				if (accept)
					x_op = scrypt_pkg::x_load;	// Block enters X at the accept edge
			st_mix_xor:
				x_op = scrypt_pkg::x_ram_xor;
			st_half_one:
				if (salsa_done)
					x_op = scrypt_pkg::x_take_x0;
			st_half_two:
				if (salsa_done)
					x_op = scrypt_pkg::x_take_x1;
			st_finish:
				x_op = scrypt_pkg::x_unload;
			default:
				x_op = scrypt_pkg::x_hold;
		endcase
	end

	assign ram_we = (state == st_write);

	// Fill walks the counter, the mix phase jumps to Integerify(X) mod N
	assign ram_addr = mix_phase ? jump_index_word[ADDR_BITS-1:0] : iter_cnt;

	always_ff @(posedge hash_clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			iter_cnt <= '0;
			mix_phase <= 1'b0;
			salsa_load <= 1'b0;
			busy <= 1'b0;
			result <= 1'b0;
		end
		else
		begin
			salsa_load <= 1'b0;	// Both strobes are single cycle
			result <= 1'b0;
			case (state)
				st_idle:
					if (accept)
					begin
						state <= st_write;
						busy <= 1'b1;
						iter_cnt <= '0;
						mix_phase <= 1'b0;
					end
				st_write:
				begin
					state <= st_half_one;
					salsa_load <= 1'b1;	// Block was written, BlockMix starts now
				end
				st_mix_read:
					state <= st_mix_xor;
				st_mix_xor:
				begin
					state <= st_half_one;
					salsa_load <= 1'b1;	// X ^ V[j] is in place at the next cycle
				end
				st_half_one:
					if (salsa_done)
					begin
						state <= st_half_two;
						salsa_load <= 1'b1;
					end
				st_half_two:
					if (salsa_done)
					begin
						iter_cnt <= iter_cnt + 1'b1;	// Wraps to zero for the mix phase
						mix_phase <= mix_phase | last_iter;
						if (mix_phase && last_iter)
							state <= st_finish;
						else if (!mix_phase && !last_iter)
							state <= st_write;
						else
							state <= st_mix_read;
					end
				st_finish:
				begin
					state <= st_idle;
					busy <= 1'b0;	// Falls together with the result pulse
					result <= 1'b1;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	result_pulse: assert property (@(posedge hash_clk) disable iff (reset) result |=> !result);
	idle_after_result: assert property (@(posedge hash_clk) disable iff (reset) result |=> !busy);

endmodule

`default_nettype wire

// ==== block_datapath.sv ====
/* Block datapath of the ROMix engine
 * Serial shift register, byte-order conversion, X0/X1 registers and the operation multiplexer
 */

`timescale 1ns/1ps
`default_nettype none

module block_datapath (
	input  logic hash_clk,
	input  logic reset,
	input  logic din,
	input  logic shift,
	input  scrypt_pkg::x_op_t x_op,
	input  logic [scrypt_pkg::HALF_BITS-1:0] salsa_out,
	input  scrypt_pkg::block_t ram_rdata,
	output logic dout,
	output logic [scrypt_pkg::HALF_BITS-1:0] salsa_in,
	output scrypt_pkg::block_t ram_wdata,
	output logic [scrypt_pkg::WORD_BITS-1:0] jump_index_word
);

	logic [scrypt_pkg::BLOCK_BITS-1:0] shift_reg;	// Host side block in byte order
	scrypt_pkg::block_t x_blk;	// Working block in little-endian words
	scrypt_pkg::block_t loaded;

	// Shift register contents as seen by the mixer
	assign loaded.flat = scrypt_pkg::byte_order(shift_reg);

	// Serial port with unload taking over for its single cycle
	always_ff @(posedge hash_clk)
	begin
		if (x_op == scrypt_pkg::x_unload)
			shift_reg <= scrypt_pkg::byte_order(x_blk.flat);
		else if (shift)
			shift_reg <= {shift_reg[scrypt_pkg::BLOCK_BITS-2:0], din};	// New bit enters at the bottom
	end

	assign dout = shift_reg[scrypt_pkg::BLOCK_BITS-1];

	// X register multiplexer
	always_ff @(posedge hash_clk)
	begin
		case (x_op)
			scrypt_pkg::x_load:
				x_blk <= loaded;
			scrypt_pkg::x_ram_xor:
				x_blk.flat <= x_blk.flat ^ ram_rdata.flat;	// X ^= V[j]
			scrypt_pkg::x_take_x0:
				x_blk.half.x0 <= salsa_out;	// Y0 replaces B0
			scrypt_pkg::x_take_x1:
				x_blk.half.x1 <= salsa_out;	// Y1 replaces B1
			default:
				x_blk <= x_blk;	// Hold and unload leave X alone
		endcase
	end

	// First half mixes B0 ^ B1, second half mixes Y0 ^ B1 once X0 has been replaced
	assign salsa_in = x_blk.half.x0 ^ x_blk.half.x1;

	assign ram_wdata = x_blk;	// Written as V[i] during the fill

	// Integerify reads the first word of the last 64 bytes
	assign jump_index_word = x_blk.half.x1[scrypt_pkg::WORD_BITS-1:0];

	// Host must keep the shift line quiet while the result is being placed
	shift_vs_unload: assert property (@(posedge hash_clk) disable iff (reset)
		!(shift && x_op == scrypt_pkg::x_unload));

endmodule

`default_nettype wire

// ==== scratchpad_ram.sv ====
/* Scratchpad RAM of 2^ADDR_BITS blocks
 * One shared address for read and write, read address registered
 */

`timescale 1ns/1ps
`default_nettype none

module scratchpad_ram #(
	parameter int ADDR_BITS = 10
) (
	input  logic hash_clk,
	input  logic [ADDR_BITS-1:0] addr,
	input  logic we,
	input  scrypt_pkg::block_t wdata,
	output scrypt_pkg::block_t rdata
);

	scrypt_pkg::block_t mem [2**ADDR_BITS];	// One entry per ROMix iteration
	logic [ADDR_BITS-1:0] addr_q;

	always_ff @(posedge hash_clk)
	begin
		if (we)
			mem[addr] <= wdata;
		addr_q <= addr;	// Registered address maps onto block RAM
	end

	// Data appears the cycle after the address was presented
	assign rdata = mem[addr_q];

endmodule

`default_nettype wire

// ==== salsa_core.sv ====
/* Iterative Salsa20/8 core
 * One double round per clock, then the captured input is added back word by word
 */

`timescale 1ns/1ps
`default_nettype none

module salsa_core (
	input  logic hash_clk,
	input  logic reset,
	input  logic load,
	input  logic [scrypt_pkg::HALF_BITS-1:0] din,
	output logic [scrypt_pkg::HALF_BITS-1:0] dout,
	output logic done
);

	localparam int CNT_BITS = $clog2(scrypt_pkg::DOUBLE_ROUNDS);
	localparam int WB = scrypt_pkg::WORD_BITS;

	logic [scrypt_pkg::HALF_BITS-1:0] work;	// State being rounded
	logic [scrypt_pkg::HALF_BITS-1:0] saved_in;	// Input kept for the final addition
	logic [CNT_BITS-1:0] round_cnt;
	logic running;

	function automatic logic [WB-1:0] rotl(input logic [WB-1:0] v, input int n);
		return (v << n) | (v >> (WB - n));
	endfunction

	// Standard Salsa quarter round, returned as {a, b, c, d}
	function automatic logic [4*WB-1:0] quarter(input logic [WB-1:0] a, input logic [WB-1:0] b,
		input logic [WB-1:0] c, input logic [WB-1:0] d);
		logic [WB-1:0] na;
		logic [WB-1:0] nb;
		logic [WB-1:0] nc;
		logic [WB-1:0] nd;
		nb = b ^ rotl(a + d, 7);
		nc = c ^ rotl(nb + a, 9);
		nd = d ^ rotl(nc + nb, 13);
		na = a ^ rotl(nd + nc, 18);
		return {na, nb, nc, nd};
	endfunction

	// Column round followed by row round, the row indices being the column ones transposed
	function automatic logic [scrypt_pkg::HALF_BITS-1:0] double_round(
		input logic [scrypt_pkg::HALF_BITS-1:0] s);
		logic [WB-1:0] x [16];
		logic [scrypt_pkg::HALF_BITS-1:0] r;
		for (int i = 0; i < 16; i++)
			x[i] = s[i*WB +: WB];
		for (int k = 0; k < 4; k++)	// Columns start on the diagonal at 5k
			{x[5*k], x[4*((k+1)%4)+k], x[4*((k+2)%4)+k], x[4*((k+3)%4)+k]} =
				quarter(x[5*k], x[4*((k+1)%4)+k], x[4*((k+2)%4)+k], x[4*((k+3)%4)+k]);
		for (int k = 0; k < 4; k++)	// Rows start on the same diagonal
			{x[5*k], x[4*k+(k+1)%4], x[4*k+(k+2)%4], x[4*k+(k+3)%4]} =
				quarter(x[5*k], x[4*k+(k+1)%4], x[4*k+(k+2)%4], x[4*k+(k+3)%4]);
		for (int i = 0; i < 16; i++)
			r[i*WB +: WB] = x[i];
		return r;
	endfunction

	always_ff @(posedge hash_clk)
	begin
		if (load)
		begin
			work <= din;
			saved_in <= din;
		end
		else if (running)
			work <= double_round(work);
	end

	always_ff @(posedge hash_clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			done <= 1'b0;
			round_cnt <= '0;
		end
		else
		begin
			done <= 1'b0;	// Single cycle pulse
			if (load)
			begin
				running <= 1'b1;
				round_cnt <= '0;
			end
			else if (running)
			begin
				round_cnt <= round_cnt + 1'b1;
				if (round_cnt == CNT_BITS'(scrypt_pkg::DOUBLE_ROUNDS - 1))
				begin
					running <= 1'b0;	// Last double round lands at this edge
					done <= 1'b1;
				end
			end
		end
	end

	// Feed-forward addition, valid from done until the next load
	always_comb
	begin
		for (int i = 0; i < 16; i++)
			dout[i*WB +: WB] = work[i*WB +: WB] + saved_in[i*WB +: WB];
	end

	// The controller must wait for done before handing over the next half
	load_while_idle: assert property (@(posedge hash_clk) disable iff (reset) load |-> !running);

endmodule

`default_nettype wire

// ==== scrypt_pkg.sv ====
/* Shared definitions for the scrypt ROMix engine
 * Block widths, the block union, the datapath operation codes and the byte-order function
 */

`default_nettype none

package scrypt_pkg;

	localparam int WORD_BITS = 32;	// One Salsa word
	localparam int HALF_BITS = 512;	// One BlockMix half (X0 or X1)
	localparam int BLOCK_BITS = 1024;	// One whole scrypt block with r = 1
	localparam int DOUBLE_ROUNDS = 4;	// Salsa20/8 runs eight rounds as four double rounds

	// The shift register and the RAM see a flat vector while the mixer works on halves
	typedef union packed {
		logic [BLOCK_BITS-1:0] flat;
		struct packed {
			logic [HALF_BITS-1:0] x1;	// Upper half holds the second 64 bytes
			logic [HALF_BITS-1:0] x0;	// Word 0 of the block sits at the least significant end
		} half;
	} block_t;

	// Operation applied to the X block at the next edge
	typedef enum logic [2:0] {
		x_hold,
		x_load,	// Take the byte-order converted shift register
		x_ram_xor,	// XOR the scratchpad read data into X
		x_take_x0,	// First BlockMix half result
		x_take_x1,	// Second BlockMix half result
		x_unload	// Hand X back to the shift register
	} x_op_t;

	// Swaps the four bytes of every 32-bit word, so it converts in both directions
	function automatic logic [BLOCK_BITS-1:0] byte_order(input logic [BLOCK_BITS-1:0] blk);
		logic [BLOCK_BITS-1:0] swapped;
		for (int w = 0; w < BLOCK_BITS / WORD_BITS; w++)
		begin
			for (int b = 0; b < WORD_BITS / 8; b++)
				swapped[w*WORD_BITS + b*8 +: 8] = blk[w*WORD_BITS + (3-b)*8 +: 8];
		end
		return swapped;
	endfunction

endpackage

`default_nettype wire
